//--- testbench/program.hex
// One 16-bit instruction word per entry, loaded from address 0 upward
// Columns: instruction words, then the assembly they encode with the first address
B134 B27F B3F0   // 0: LLB r1,0x34   LLB r2,0x7F   LLB r3,0xF0
A112 A27F A380   // 3: LHB r1,0x12   LHB r2,0x7F   LHB r3,0x80
0411 2521 2632   // 6: ADD r4,r1,r1   SUB r5,r2,r1   SUB r6,r3,r2 (overflow)
CC03             // 9: B OVF +3, taken to 13
BE10 BE11 BE12   // 10: shadow, flushed
2712 C203        // 13: SUB r7,r1,r2 (negative)   B EQ +3, not taken
3823 4913        // 15: AND r8,r2,r3   NOR r9,r1,r3
C603             // 17: B LT +3, taken to 21
BE18 BE19 BE20   // 18: shadow, flushed
5A14 6B34 7C34   // 21: SLL r10,r1,4   SRL r11,r3,4   SRA r12,r3,4
2D11 1E12        // 24: SUB r13,r1,r1 (zero)   ADDZ r14,r1,r2 writes
6D28 1C11        // 26: SRL r13,r2,8   ADDZ r12,r1,r1 silent
9105 8505 8607   // 28: SW r1,5(r0)   LW r5,5(r0)   LW r6,7(r0)
D003             // 31: JAL +3 to 35, r15 = 32
C007             // 32: B NEQ +7 to 40, runs after JR
BE33 BE34        // 33: shadow, flushed
B85A             // 35: LLB r8,0x5A
E0F0             // 36: JR r15
BE37 BE38 BE39   // 37: shadow, flushed
07F8             // 40: ADD r7,r15,r8
F000             // 41: HLT

//--- compile.f
hw/cpuPkg.sv
hw/instructionFetch.sv
hw/instructionDecode.sv
hw/execute.sv
hw/memory.sv
hw/cpu.sv
testbench/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the cpu testbench with Verilator and run it.
# The ROM loads program.hex from the working directory, so the model runs in testbench/.
cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module cpuTb -o cpuTbSim \
  && (cd testbench && ../obj_dir/cpuTbSim) > sim.log 2>&1 \
  || { echo "Build or simulation failed, see sim.log"; exit 1; }

grep -q "Done: no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- testbench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_ENTRIES = 23;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 40 + RESET_CYCLES;
  // Word address of the HLT in program.hex
  localparam logic [15:0] HLT_ADDR = 16'd41;
  // Cycles watched after hlt rises to cover the drain plus 20 quiet cycles
  localparam int QUIET_CYCLES = 25;
  // Pc values checked one by one after reset and before the first branch
  localparam int PC_STEPS = 8;

  // ****************************************
  // Expected writebacks, in retire order
  // ****************************************
  // Top hex digit is the register and the low four digits the value
  localparam logic [19:0] EXPECTED [NUM_ENTRIES] = '{
    20'h1_0034, 20'h2_007F, 20'h3_00F0,   // LLB
    20'h1_1234, 20'h2_7F7F, 20'h3_80F0,   // LHB keeps the low byte
    20'h4_2468,                           // ADD r1+r1
    20'h5_6D4B,                           // SUB without overflow
    20'h6_0171,                           // SUB with signed overflow
    20'h7_92B5,                           // SUB with a negative result
    20'h8_0070, 20'h9_6D0B,               // AND and NOR
    20'hA_2340, 20'hB_080F, 20'hC_F80F,   // SLL, SRL and SRA by 4
    20'hD_0000,                           // SUB to zero sets the zero flag
    20'hE_91B3,                           // ADDZ after zero
    20'hD_007F,                           // SRL clears zero so the next ADDZ is silent
    20'h5_1234, 20'h6_0000,               // LW after SW and LW of an untouched word
    20'hF_0020,                           // JAL return address
    20'h8_005A,                           // JAL target
    20'h7_007A                            // after JR and the NEQ branch
  };

  logic clk;
  logic rst_n;
  logic hlt;
  cpuPkg::word pc;
  logic writeEnable;
  cpuPkg::regAddr writeAddr;
  cpuPkg::word writeData;

  int mismatchCount;
  int otherCount;
  int entryIdx;

  cpu i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .hlt        (hlt),
    .pc         (pc),
    .writeEnable(writeEnable),
    .writeAddr  (writeAddr),
    .writeData  (writeData)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      mismatchCount++;
    end
  endtask

  task automatic printCounts();
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
  endtask

  // ****************************************
  // Writeback monitor
  // ****************************************
  initial begin : writebackMonitor
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (writeEnable === 1'b1) begin
        if (entryIdx < NUM_ENTRIES) begin
          checkValue(16'(writeAddr), 16'(EXPECTED[entryIdx][19:16]),
                     $sformatf("register of writeback %0d", entryIdx));
          checkValue(writeData, EXPECTED[entryIdx][15:0],
                     $sformatf("value of writeback %0d", entryIdx));
        end else begin
          $display("Unexpected writeback at %0d ns: r%0d written with %h after the last entry",
                   $time, writeAddr, writeData);
          otherCount++;
        end
        entryIdx++;
      end
    end
  end

  // Ends a run that hangs
  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    if (hlt !== 1'b1) begin
      $display("Timeout after %0d cycles: hlt never rose", WATCHDOG_CYCLES);
    end else begin
      $display("Timeout after %0d cycles: the run did not finish", WATCHDOG_CYCLES);
    end
    otherCount++;
    printCounts();
    $display("Done: errors found");
    $finish;
  end

  initial begin : mainSequence
    rst_n = 1'b0;
    mismatchCount = 0;
    otherCount = 0;
    entryIdx = 0;

    // Quiet outputs while reset is held
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      checkValue(pc, 16'h0000, "pc in reset");
      checkValue(16'(hlt), 16'h0000, "hlt in reset");
      checkValue(16'(writeEnable), 16'h0000, "writeEnable in reset");
    end
    @(posedge clk);
    #1 rst_n = 1'b1;

    // First cycle out of reset
    @(negedge clk);
    checkValue(pc, 16'h0000, "pc after reset");
    checkValue(16'(hlt), 16'h0000, "hlt after reset");
    checkValue(16'(writeEnable), 16'h0000, "writeEnable after reset");

    // One word per cycle through the straight-line start of the program
    for (int k = 1; k <= PC_STEPS; k++) begin
      @(negedge clk);
      checkValue(pc, 16'(k), $sformatf("pc in cycle %0d after reset", k));
    end

    wait (hlt === 1'b1);
    // hlt sticks and pc parks on HLT while the pipe drains
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      checkValue(16'(hlt), 16'h0001, "hlt after halt");
      checkValue(pc, HLT_ADDR, "pc after halt");
    end
    @(posedge clk);

    if (entryIdx < NUM_ENTRIES) begin
      $display("Missing writebacks: only %0d of %0d expected register writes occurred",
               entryIdx, NUM_ENTRIES);
      otherCount++;
    end

    printCounts();
    if (mismatchCount + otherCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic           clk,
  input  logic           rst_n,
  output logic           hlt,
  output cpuPkg::word    pc,
  output logic           writeEnable,
  output cpuPkg::regAddr writeAddr,
  output cpuPkg::word    writeData
);

  // Fetch and redirect
  cpuPkg::word pcNextIf;
  cpuPkg::word instrIf;
  cpuPkg::word branchAddr;
  logic branch;
  logic flush;

  cpuPkg::word instrIfId;
  cpuPkg::word pcNextIfId;
  logic validIfId;

  // Decode outputs
  cpuPkg::word p0Id;
  cpuPkg::word p1Id;
  cpuPkg::imm immId;
  cpuPkg::regAddr regAddrId;
  logic [3:0] shamtId;
  cpuPkg::aluOp aluOpId;
  cpuPkg::branchCond branchOpId;
  logic regWeId, memReId, memWeId, memToRegId, addzId;
  logic branchInstrId, jalId, jrId, aluSrc0Id, aluSrc1Id;
  logic ovEnId, zrEnId, neEnId;
  logic idLive;

  cpuPkg::word p0IdEx;
  cpuPkg::word p1IdEx;
  cpuPkg::word pcNextIdEx;
  cpuPkg::imm immIdEx;
  cpuPkg::regAddr regAddrIdEx;
  logic [3:0] shamtIdEx;
  cpuPkg::aluOp aluOpIdEx;
  cpuPkg::branchCond branchOpIdEx;
  logic aluSrc0IdEx, aluSrc1IdEx;
  logic regWeIdEx, memReIdEx, memWeIdEx, memToRegIdEx, addzIdEx;
  logic branchInstrIdEx, jalIdEx, jrIdEx, ovEnIdEx, zrEnIdEx, neEnIdEx;

  // Execute outputs
  cpuPkg::word aluResultEx;
  cpuPkg::word branchResultEx;
  cpuPkg::word jumpResultEx;
  logic ovEx, zrEx, neEx;

  cpuPkg::word aluResultExMem;
  cpuPkg::word branchResultExMem;
  cpuPkg::word jumpResultExMem;
  cpuPkg::word p0ExMem;
  cpuPkg::word p1ExMem;
  cpuPkg::word pcNextExMem;
  cpuPkg::regAddr regAddrExMem;
  cpuPkg::branchCond branchOpExMem;
  logic ovExMem, zrExMem, neExMem;
  logic regWeExMem, memReExMem, memWeExMem, memToRegExMem, addzExMem;
  logic branchInstrExMem, jalExMem, jrExMem, ovEnExMem, zrEnExMem, neEnExMem;

  logic ovFlag, zrFlag, neFlag;
  cpuPkg::word memDataMem;
  logic regWeMem;

  cpuPkg::word pcNextMemWb;
  cpuPkg::word aluResultMemWb;
  cpuPkg::regAddr regAddrMemWb;
  logic regWeMemWb, memToRegMemWb, jalMemWb;

  instructionFetch uFetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .branch    (branch),
    .branchAddr(branchAddr),
    .pc        (pc),
    .pcNext    (pcNextIf),
    .instr     (instrIf),
    .hlt       (hlt)
  );

  // ****************************************
  // IF/ID
  // ****************************************
  always_ff @(posedge clk) begin
    instrIfId  <= instrIf;
    pcNextIfId <= pcNextIf;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validIfId <= 1'b0;
    end else begin
      validIfId <= !flush;
    end
  end

  instructionDecode uDecode (
    .clk        (clk),
    .rst_n      (rst_n),
    .hlt        (hlt),
    .instr      (instrIfId),
    .writeData  (writeData),
    .writeAddr  (writeAddr),
    .writeEnable(writeEnable),
    .p0         (p0Id),
    .p1         (p1Id),
    .imm        (immId),
    .regAddr    (regAddrId),
    .shamt      (shamtId),
    .aluOp      (aluOpId),
    .branchOp   (branchOpId),
    .regWe      (regWeId),
    .memRe      (memReId),
    .memWe      (memWeId),
    .memToReg   (memToRegId),
    .addz       (addzId),
    .branchInstr(branchInstrId),
    .jal        (jalId),
    .jr         (jrId),
    .aluSrc0    (aluSrc0Id),
    .aluSrc1    (aluSrc1Id),
    .ovEn       (ovEnId),
    .zrEn       (zrEnId),
    .neEn       (neEnId)
  );

  // ****************************************
  // ID/EX
  // ****************************************
  assign idLive = validIfId && !flush;

  always_ff @(posedge clk) begin
    p0IdEx       <= p0Id;
    p1IdEx       <= p1Id;
    pcNextIdEx   <= pcNextIfId;
    immIdEx      <= immId;
    regAddrIdEx  <= regAddrId;
    shamtIdEx    <= shamtId;
    aluOpIdEx    <= aluOpId;
    branchOpIdEx <= branchOpId;
    aluSrc0IdEx  <= aluSrc0Id;
    aluSrc1IdEx  <= aluSrc1Id;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regWeIdEx       <= 1'b0;
      memReIdEx       <= 1'b0;
      memWeIdEx       <= 1'b0;
      memToRegIdEx    <= 1'b0;
      addzIdEx        <= 1'b0;
      branchInstrIdEx <= 1'b0;
      jalIdEx         <= 1'b0;
      jrIdEx          <= 1'b0;
      ovEnIdEx        <= 1'b0;
      zrEnIdEx        <= 1'b0;
      neEnIdEx        <= 1'b0;
    end else begin
      regWeIdEx       <= regWeId && idLive;
      memReIdEx       <= memReId && idLive;
      memWeIdEx       <= memWeId && idLive;
      memToRegIdEx    <= memToRegId && idLive;
      addzIdEx        <= addzId && idLive;
      branchInstrIdEx <= branchInstrId && idLive;
      jalIdEx         <= jalId && idLive;
      jrIdEx          <= jrId && idLive;
      ovEnIdEx        <= ovEnId && idLive;
      zrEnIdEx        <= zrEnId && idLive;
      neEnIdEx        <= neEnId && idLive;
    end
  end

  execute uExecute (
    .p0          (p0IdEx),
    .p1          (p1IdEx),
    .pcNext      (pcNextIdEx),
    .imm         (immIdEx),
    .shamt       (shamtIdEx),
    .aluOp       (aluOpIdEx),
    .aluSrc0     (aluSrc0IdEx),
    .aluSrc1     (aluSrc1IdEx),
    .aluResult   (aluResultEx),
    .branchResult(branchResultEx),
    .jumpResult  (jumpResultEx),
    .ov          (ovEx),
    .zr          (zrEx),
    .ne          (neEx)
  );

  // ****************************************
  // EX/MEM
  // ****************************************
  always_ff @(posedge clk) begin
    aluResultExMem    <= aluResultEx;
    branchResultExMem <= branchResultEx;
    jumpResultExMem   <= jumpResultEx;
    p0ExMem           <= p0IdEx;
    p1ExMem           <= p1IdEx;
    pcNextExMem       <= pcNextIdEx;
    regAddrExMem      <= regAddrIdEx;
    branchOpExMem     <= branchOpIdEx;
    ovExMem           <= ovEx;
    zrExMem           <= zrEx;
    neExMem           <= neEx;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regWeExMem       <= 1'b0;
      memReExMem       <= 1'b0;
      memWeExMem       <= 1'b0;
      memToRegExMem    <= 1'b0;
      addzExMem        <= 1'b0;
      branchInstrExMem <= 1'b0;
      jalExMem         <= 1'b0;
      jrExMem          <= 1'b0;
      ovEnExMem        <= 1'b0;
      zrEnExMem        <= 1'b0;
      neEnExMem        <= 1'b0;
    end else begin
      regWeExMem       <= regWeIdEx && !flush;
      memReExMem       <= memReIdEx && !flush;
      memWeExMem       <= memWeIdEx && !flush;
      memToRegExMem    <= memToRegIdEx && !flush;
      addzExMem        <= addzIdEx && !flush;
      branchInstrExMem <= branchInstrIdEx && !flush;
      jalExMem         <= jalIdEx && !flush;
      jrExMem          <= jrIdEx && !flush;
      ovEnExMem        <= ovEnIdEx && !flush;
      zrEnExMem        <= zrEnIdEx && !flush;
      neEnExMem        <= neEnIdEx && !flush;
    end
  end

  // Flags follow the instruction leaving MEM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ovFlag <= 1'b0;
      zrFlag <= 1'b0;
      neFlag <= 1'b0;
    end else begin
      if (ovEnExMem) begin
        ovFlag <= ovExMem;
      end
      if (zrEnExMem) begin
        zrFlag <= zrExMem;
      end
      if (neEnExMem) begin
        neFlag <= neExMem;
      end
    end
  end

  memory uMemory (
    .clk           (clk),
    .memAddr       (aluResultExMem),
    .memRe         (memReExMem),
    .memWe         (memWeExMem),
    .regWe         (regWeExMem),
    .wrtData       (p1ExMem),
    .zr            (zrFlag),
    .ne            (neFlag),
    .ov            (ovFlag),
    .addz          (addzExMem),
    .b             (branchInstrExMem),
    .jal           (jalExMem),
    .jr            (jrExMem),
    .jalResult     (jumpResultExMem),
    .jrResult      (p0ExMem),
    .branchResult  (branchResultExMem),
    .branchOp      (branchOpExMem),
    .memData       (memDataMem),
    .regWriteEnable(regWeMem),
    .flush         (flush),
    .branchAddr    (branchAddr),
    .branch        (branch)
  );

  // ****************************************
  // MEM/WB and writeback select
  // ****************************************
  always_ff @(posedge clk) begin
    pcNextMemWb    <= pcNextExMem;
    aluResultMemWb <= aluResultExMem;
    regAddrMemWb   <= regAddrExMem;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regWeMemWb    <= 1'b0;
      memToRegMemWb <= 1'b0;
      jalMemWb      <= 1'b0;
    end else begin
      regWeMemWb    <= regWeMem;
      memToRegMemWb <= memToRegExMem;
      jalMemWb      <= jalExMem;
    end
  end

  // Load data comes straight from the RAM output register
  assign writeEnable = regWeMemWb;
  assign writeAddr   = jalMemWb ? 4'd15 : regAddrMemWb;
  assign writeData   = jalMemWb ? pcNextMemWb :
                       (memToRegMemWb ? memDataMem : aluResultMemWb);

endmodule

`default_nettype wire

//--- hw/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory (
  input  logic              clk,
  input  cpuPkg::word       memAddr,
  input  logic              memRe,
  input  logic              memWe,
  input  logic              regWe,
  input  cpuPkg::word       wrtData,
  input  logic              zr,
  input  logic              ne,
  input  logic              ov,
  input  logic              addz,
  input  logic              b,
  input  logic              jal,
  input  logic              jr,
  input  cpuPkg::word       jalResult,
  input  cpuPkg::word       jrResult,
  input  cpuPkg::word       branchResult,
  input  cpuPkg::branchCond branchOp,
  output cpuPkg::word       memData,
  output logic              regWriteEnable,
  output logic              flush,
  output cpuPkg::word       branchAddr,
  output logic              branch
);

  localparam int ADDR_BITS = $clog2(cpuPkg::DMEM_DEPTH);

  cpuPkg::word ram [cpuPkg::DMEM_DEPTH];
  logic condMet;

  // ****************************************
  // Data RAM
  // ****************************************
  initial begin
    for (int i = 0; i < cpuPkg::DMEM_DEPTH; i++) begin
      ram[i] = '0;
    end
  end

  // Registered read, data shows up in the writeback cycle
  always @(posedge clk) begin
    if (memWe) begin
      ram[memAddr[ADDR_BITS-1:0]] <= wrtData;
    end
    if (memRe) begin
      memData <= ram[memAddr[ADDR_BITS-1:0]];
    end
  end

  // ADDZ only retires when the last flag update saw zero
  assign regWriteEnable = regWe && !(addz && !zr);

  // ****************************************
  // Branch resolution
  // ****************************************
  always_comb begin
    case (branchOp)
      cpuPkg::COND_NEQ:    condMet = !zr;
      cpuPkg::COND_EQ:     condMet = zr;
      cpuPkg::COND_GT:     condMet = !zr && !ne;
      cpuPkg::COND_LT:     condMet = ne;
      cpuPkg::COND_GTE:    condMet = zr || !ne;
      cpuPkg::COND_LTE:    condMet = zr || ne;
      cpuPkg::COND_OVF:    condMet = ov;
      cpuPkg::COND_UNCOND: condMet = 1'b1;
      default:             condMet = 1'b0;
    endcase
  end

  assign branch     = (b && condMet) || jal || jr;
  assign branchAddr = jal ? jalResult : (jr ? jrResult : branchResult);
  // Kills the three younger stages on a redirect
  assign flush      = branch;

endmodule

`default_nettype wire

//--- hw/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  cpuPkg::word  p0,
  input  cpuPkg::word  p1,
  input  cpuPkg::word  pcNext,
  input  cpuPkg::imm   imm,
  input  logic [3:0]   shamt,
  input  cpuPkg::aluOp aluOp,
  input  logic         aluSrc0,
  input  logic         aluSrc1,
  output cpuPkg::word  aluResult,
  output cpuPkg::word  branchResult,
  output cpuPkg::word  jumpResult,
  output logic         ov,
  output logic         zr,
  output logic         ne
);

  cpuPkg::word immOperand;
  cpuPkg::word opB;
  cpuPkg::word sum;
  cpuPkg::word diff;

  // aluSrc0 picks the zero extended LLB byte over the 4-bit LW/SW offset
  assign immOperand = aluSrc0 ? {8'h00, imm[7:0]} : {{12{imm[3]}}, imm[3:0]};
  assign opB        = aluSrc1 ? immOperand : p1;

  assign sum  = p0 + opB;
  assign diff = p0 - opB;

  always_comb begin
    aluResult = sum;
    ov        = 1'b0;
    case (aluOp)
      cpuPkg::ALU_ADD: begin
        aluResult = sum;
        ov        = (p0[15] == opB[15]) && (sum[15] != p0[15]);
      end
      cpuPkg::ALU_SUB: begin
        aluResult = diff;
        ov        = (p0[15] != opB[15]) && (diff[15] != p0[15]);
      end
      cpuPkg::ALU_AND: aluResult = p0 & opB;
      cpuPkg::ALU_NOR: aluResult = ~(p0 | opB);
      cpuPkg::ALU_SLL: aluResult = p0 << shamt;
      cpuPkg::ALU_SRL: aluResult = p0 >> shamt;
      cpuPkg::ALU_SRA: aluResult = cpuPkg::word'($signed(p0) >>> shamt);
      // New upper byte, lower byte kept from rd
      cpuPkg::ALU_LHB: aluResult = {imm[7:0], p0[7:0]};
      default:         aluResult = sum;
    endcase
  end

  assign zr = (aluResult == 16'h0000);
  assign ne = aluResult[15];

  // Targets relative to the word after the branch
  assign branchResult = pcNext + {{7{imm[8]}}, imm[8:0]};
  assign jumpResult   = pcNext + {{4{imm[11]}}, imm};

endmodule

`default_nettype wire

//--- hw/instructionDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              hlt,
  input  cpuPkg::word       instr,
  input  cpuPkg::word       writeData,
  input  cpuPkg::regAddr    writeAddr,
  input  logic              writeEnable,
  output cpuPkg::word       p0,
  output cpuPkg::word       p1,
  output cpuPkg::imm        imm,
  output cpuPkg::regAddr    regAddr,
  output logic [3:0]        shamt,
  output cpuPkg::aluOp      aluOp,
  output cpuPkg::branchCond branchOp,
  output logic              regWe,
  output logic              memRe,
  output logic              memWe,
  output logic              memToReg,
  output logic              addz,
  output logic              branchInstr,
  output logic              jal,
  output logic              jr,
  output logic              aluSrc0,
  output logic              aluSrc1,
  output logic              ovEn,
  output logic              zrEn,
  output logic              neEn
);

  cpuPkg::word regFile [16];
  cpuPkg::opcode op;
  cpuPkg::regAddr readAddr0;
  cpuPkg::regAddr readAddr1;

  assign op       = cpuPkg::opcode'(instr[15:12]);
  assign imm      = instr[11:0];
  assign regAddr  = instr[11:8];
  assign shamt    = instr[3:0];
  assign branchOp = cpuPkg::branchCond'(instr[11:9]);

  // Port 0 reads rd for LHB, r0 for LLB and rs otherwise
  assign readAddr0 = (op == cpuPkg::OP_LHB) ? instr[11:8] :
                     (op == cpuPkg::OP_LLB) ? 4'h0 : instr[7:4];
  // SW stores rt, which sits in the rd slot
  assign readAddr1 = (op == cpuPkg::OP_SW) ? instr[11:8] : instr[3:0];

  // ****************************************
  // Register file
  // ****************************************
  // Falling edge write lands before the read of the same cycle
  always_ff @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regFile[i] <= '0;
      end
    end else if (writeEnable && (writeAddr != 4'h0)) begin
      regFile[writeAddr] <= writeData;
    end
  end

  assign p0 = (readAddr0 == 4'h0) ? '0 : regFile[readAddr0];
  assign p1 = (readAddr1 == 4'h0) ? '0 : regFile[readAddr1];

  // ****************************************
  // Control decode
  // ****************************************
  always_comb begin
    case (op)
      cpuPkg::OP_SUB: aluOp = cpuPkg::ALU_SUB;
      cpuPkg::OP_AND: aluOp = cpuPkg::ALU_AND;
      cpuPkg::OP_NOR: aluOp = cpuPkg::ALU_NOR;
      cpuPkg::OP_SLL: aluOp = cpuPkg::ALU_SLL;
      cpuPkg::OP_SRL: aluOp = cpuPkg::ALU_SRL;
      cpuPkg::OP_SRA: aluOp = cpuPkg::ALU_SRA;
      cpuPkg::OP_LHB: aluOp = cpuPkg::ALU_LHB;
      default:        aluOp = cpuPkg::ALU_ADD;
    endcase
  end

  always_comb begin
    regWe       = 1'b0;
    memRe       = 1'b0;
    memWe       = 1'b0;
    memToReg    = 1'b0;
    addz        = 1'b0;
    branchInstr = 1'b0;
    jal         = 1'b0;
    jr          = 1'b0;
    aluSrc0     = 1'b0;
    aluSrc1     = 1'b0;
    ovEn        = 1'b0;
    zrEn        = 1'b0;
    neEn        = 1'b0;
    // Nothing fetched behind HLT may change state
    if (!hlt) begin
      case (op)
        cpuPkg::OP_ADD, cpuPkg::OP_SUB: begin
          regWe = 1'b1;
          ovEn  = 1'b1;
          zrEn  = 1'b1;
          neEn  = 1'b1;
        end
        cpuPkg::OP_ADDZ: begin
          regWe = 1'b1;
          addz  = 1'b1;
        end
        cpuPkg::OP_AND, cpuPkg::OP_NOR, cpuPkg::OP_SLL, cpuPkg::OP_SRL, cpuPkg::OP_SRA: begin
          regWe = 1'b1;
          zrEn  = 1'b1;
        end
        cpuPkg::OP_LW: begin
          regWe    = 1'b1;
          memRe    = 1'b1;
          memToReg = 1'b1;
          aluSrc1  = 1'b1;
        end
        cpuPkg::OP_SW: begin
          memWe   = 1'b1;
          aluSrc1 = 1'b1;
        end
        cpuPkg::OP_LHB: regWe = 1'b1;
        cpuPkg::OP_LLB: begin
          regWe   = 1'b1;
          aluSrc0 = 1'b1;
          aluSrc1 = 1'b1;
        end
        cpuPkg::OP_B:   branchInstr = 1'b1;
        cpuPkg::OP_JAL: begin
          regWe = 1'b1;
          jal   = 1'b1;
        end
        cpuPkg::OP_JR:  jr = 1'b1;
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/instructionFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instructionFetch (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        branch,
  input  cpuPkg::word branchAddr,
  output cpuPkg::word pc,
  output cpuPkg::word pcNext,
  output cpuPkg::word instr,
  output logic        hlt
);

  localparam int PC_BITS = $clog2(cpuPkg::IMEM_DEPTH);

  cpuPkg::word rom [cpuPkg::IMEM_DEPTH];
  logic isHlt;

  initial begin
    $readmemh("program.hex", rom);
  end

  // Asynchronous ROM read, pc counts words
  assign instr  = rom[pc[PC_BITS-1:0]];
  assign pcNext = pc + 16'd1;
  assign isHlt  = (cpuPkg::opcode'(instr[15:12]) == cpuPkg::OP_HLT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc  <= '0;
      hlt <= 1'b0;
    end else begin
      // A taken branch wins, the instruction fetched now is in its shadow
      if (branch) begin
        pc <= branchAddr;
      end else if (!isHlt && !hlt) begin
        pc <= pcNext;
      end
      // Sticky halt, pc stays on the HLT word
      if (isHlt && !branch) begin
        hlt <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // Word counts of the two memories
  localparam int IMEM_DEPTH = 256;
  localparam int DMEM_DEPTH = 256;

  // Data value or word address
  typedef logic [15:0] word;
  // Register number
  typedef logic [3:0] regAddr;
  // Raw immediate field, bits 11..0 of an instruction
  typedef logic [11:0] imm;

  // ****************************************
  // Instruction set
  // ****************************************
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_ADDZ = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_NOR  = 4'h4,
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    OP_SRA  = 4'h7,
    OP_LW   = 4'h8,
    OP_SW   = 4'h9,
    OP_LHB  = 4'hA,
    OP_LLB  = 4'hB,
    OP_B    = 4'hC,
    OP_JAL  = 4'hD,
    OP_JR   = 4'hE,
    OP_HLT  = 4'hF
  } opcode;

  // Condition field of B, bits 11..9
  typedef enum logic [2:0] {
    COND_NEQ    = 3'd0,
    COND_EQ     = 3'd1,
    COND_GT     = 3'd2,
    COND_LT     = 3'd3,
    COND_GTE    = 3'd4,
    COND_LTE    = 3'd5,
    COND_OVF    = 3'd6,
    COND_UNCOND = 3'd7
  } branchCond;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_NOR = 3'd3,
    ALU_SLL = 3'd4,
    ALU_SRL = 3'd5,
    ALU_SRA = 3'd6,
    ALU_LHB = 3'd7
  } aluOp;

endpackage

`default_nettype wire
